/* gpgpu_settings.svh */
// Cluster build-time sizes, shared by every RTL file and the testbench
// QUEUE_DEPTH must be a power of two and at least 2
// MEM_WORDS sets the address width, a power of two keeps the map dense
// NUM_CORES above 1 gives a real round-robin, 1 still builds
`ifndef GPGPU_SETTINGS_SVH
`define GPGPU_SETTINGS_SVH

// Number of cores, one request queue each
`define NUM_CORES 4

// Entries per core request queue
`define QUEUE_DEPTH 4

// Words in the shared L2 store
`define MEM_WORDS 64

// Bits per data word
`define DATA_WIDTH 32

`endif

/* cluster_pkg.sv */
// Cluster organization types: core numbering and queue occupancy
// Core index is at least one bit wide even for a single core
`default_nettype none

`include "gpgpu_settings.svh"

package cluster_pkg;

	localparam int CORE_W = (`NUM_CORES > 1) ? $clog2(`NUM_CORES) : 1; // Core number bits
	localparam int COUNT_W = $clog2(`QUEUE_DEPTH) + 1; // Holds 0 .. QUEUE_DEPTH

	typedef logic [CORE_W-1:0] core_index_t; // Core number
	typedef logic [COUNT_W-1:0] queue_count_t; // Entries in one core queue

endpackage

`default_nettype wire

/* l2_pkg.sv */
// Memory-side types: L2 request and response words
// The request and response carry the same fields
// Address is a word index, there is no byte addressing
`default_nettype none

`include "gpgpu_settings.svh"

package l2_pkg;

	localparam int ADDR_W = (`MEM_WORDS > 1) ? $clog2(`MEM_WORDS) : 1; // Word address bits

	typedef logic [`DATA_WIDTH-1:0] l2_data_t; // One data word
	typedef logic [ADDR_W-1:0] l2_addr_t; // Word index into the store
	typedef logic l2_op_t; // Load or store

	localparam l2_op_t OP_LOAD = 1'b0;
	localparam l2_op_t OP_STORE = 1'b1;

	// L1 miss traffic towards L2
	typedef struct packed {
		cluster_pkg::core_index_t core; // Requesting core
		l2_op_t op;
		l2_addr_t address;
		l2_data_t data; // Store data, ignored on loads
	} l2_request_t;

	// Broadcast back to every core, core selects the receiver
	typedef struct packed {
		cluster_pkg::core_index_t core;
		l2_op_t op;
		l2_addr_t address;
		l2_data_t data; // Read word, or the stored word as ack
	} l2_response_t;

endpackage

`default_nettype wire

/* request_dispatch.sv */
// Host request intake and routing into the per-core queues
// One holding register; a blocked push stalls the host through host_ready
// host_req must stay stable while host_valid is high and host_ready low
// host_ready stays low for one cycle after reset is released
`timescale 1ns/10ps
`default_nettype none

`include "gpgpu_settings.svh"

module request_dispatch (
	input wire clk,
	input wire reset,
	input wire host_valid,
	output logic host_ready,
	input wire l2_pkg::l2_request_t host_req,
	input wire [`NUM_CORES-1:0] queue_full,
	output logic [`NUM_CORES-1:0] push,
	output l2_pkg::l2_request_t push_req,
	output logic holding
);
	import l2_pkg::*;
	import cluster_pkg::*;

	logic run_en; // Set one edge after reset
	logic hold_valid;
	l2_request_t hold_req; // Held request payload
	logic push_ok;

	assign push_ok = hold_valid && !queue_full[hold_req.core]; // Target queue has room
	assign host_ready = run_en && (!hold_valid || push_ok); // Free now or freed this edge
	assign push_req = hold_req;
	assign holding = hold_valid;

	always_comb
	begin
		for (int i = 0; i < `NUM_CORES; i++)
			push[i] = push_ok && (hold_req.core == core_index_t'(i)); // Decode target core
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			run_en <= 1'b0;
			hold_valid <= 1'b0;
		end
		else
		begin
			run_en <= 1'b1;
			if (host_valid && host_ready)
				hold_valid <= 1'b1; // Refill, possibly same edge as a push
			else if (push_ok)
				hold_valid <= 1'b0; // Drained into its queue
		end
	end

	always_ff @(posedge clk)
	begin
		if (host_valid && host_ready)
			hold_req <= host_req;
	end

	// Host keeps an offered request steady until it is taken
	assert property (@(posedge clk) disable iff (reset)
		host_valid && !host_ready |=> !host_valid || $stable(host_req));

endmodule

`default_nettype wire

/* core_queue.sv */
// Per-core FIFO of pending L2 requests
// QUEUE_DEPTH entries, power of two, pointers wrap naturally
// Head is registered storage, a push shows at the head one cycle later
// Caller must not push when full nor pop when empty
`timescale 1ns/10ps
`default_nettype none

`include "gpgpu_settings.svh"

module core_queue (
	input wire clk,
	input wire reset,
	input wire push,
	input wire l2_pkg::l2_request_t push_req,
	output logic full,
	output logic valid,
	output l2_pkg::l2_request_t head,
	input wire pop
);
	import l2_pkg::*;
	import cluster_pkg::*;

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);

	l2_request_t entries [`QUEUE_DEPTH]; // Queued requests
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	queue_count_t count;

	assign full = (count == queue_count_t'(`QUEUE_DEPTH));
	assign valid = (count != '0);
	assign head = entries[rd_ptr]; // Oldest entry

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= push_req;
	end

	// Dispatcher must respect full
	assert property (@(posedge clk) disable iff (reset) push |-> !full);

	// L2 arbiter only grants queues that hold something
	assert property (@(posedge clk) disable iff (reset) pop |-> valid);

endmodule

`default_nettype wire

/* l2_store.sv */
// Shared L2 word store with a round-robin arbiter over the core queues
// One request serviced per cycle, response one cycle after the grant
// rsp_valid is a single-cycle strobe, receivers cannot stall it
// Memory contents are undefined until written
`timescale 1ns/10ps
`default_nettype none

`include "gpgpu_settings.svh"

module l2_store (
	input wire clk,
	input wire reset,
	input wire [`NUM_CORES-1:0] req_valid,
	input wire l2_pkg::l2_request_t [`NUM_CORES-1:0] req,
	output logic [`NUM_CORES-1:0] pop,
	output logic rsp_valid,
	output l2_pkg::l2_response_t rsp,
	output logic active
);
	import l2_pkg::*;
	import cluster_pkg::*;

	l2_data_t mem [`MEM_WORDS]; // Shared word storage
	core_index_t last_grant; // Core served most recently
	core_index_t grant_idx;
	logic grant_valid;
	l2_request_t grant_req;

	// Search starts one past the last winner
	always_comb
	begin
		int cand;
		grant_valid = 1'b0;
		grant_idx = last_grant;
		pop = '0;
		for (int i = 1; i <= `NUM_CORES; i++)
		begin
			cand = (int'(last_grant) + i) % `NUM_CORES;
			if (!grant_valid && req_valid[cand])
			begin
				grant_valid = 1'b1;
				grant_idx = core_index_t'(cand);
			end
		end
		pop[grant_idx] = grant_valid; // Pop in the grant cycle
	end

	assign grant_req = req[grant_idx]; // Head of the winning queue
	assign active = rsp_valid; // Response register occupied

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rsp_valid <= 1'b0;
			last_grant <= core_index_t'(`NUM_CORES - 1); // Core 0 wins first
		end
		else
		begin
			rsp_valid <= grant_valid; // One-cycle strobe
			if (grant_valid)
				last_grant <= grant_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant_valid)
		begin
			if (grant_req.op == OP_STORE)
				mem[grant_req.address] <= grant_req.data;
			rsp.core <= grant_req.core;
			rsp.op <= grant_req.op;
			rsp.address <= grant_req.address;
			// Registered read, stores echo their data as ack
			if (grant_req.op == OP_LOAD)
				rsp.data <= mem[grant_req.address];
			else
				rsp.data <= grant_req.data;
		end
	end

	// Same core never wins twice in a row while another queue waits
	assert property (@(posedge clk) disable iff (reset)
		grant_valid |=> !(pop == $past(pop) && (req_valid & ~pop) != '0));

endmodule

`default_nettype wire

/* gpgpu_cluster.sv */
// Memory side of the GPGPU cluster: dispatcher, per-core queues, shared L2
// Host port stands in for the cores' L1 miss traffic
// Response bus is broadcast, rsp.core names the receiver
// Per-core order is kept, cross-core order follows the arbiter
`timescale 1ns/10ps
`default_nettype none

`include "gpgpu_settings.svh"

module gpgpu_cluster (
	input wire clk,
	input wire reset,
	input wire host_valid,
	output logic host_ready,
	input wire l2_pkg::l2_request_t host_req,
	output logic rsp_valid,
	output l2_pkg::l2_response_t rsp,
	output logic busy
);
	import l2_pkg::*;

	logic [`NUM_CORES-1:0] queue_full;
	logic [`NUM_CORES-1:0] push; // One bit per core queue
	l2_request_t push_req; // Shared by all queues
	logic holding;
	logic [`NUM_CORES-1:0] queue_valid;
	l2_request_t [`NUM_CORES-1:0] queue_head;
	logic [`NUM_CORES-1:0] pop;
	logic active;

	assign busy = holding || (|queue_valid) || active; // Anything in flight

	request_dispatch u_dispatch (
		.clk(clk),
		.reset(reset),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.host_req(host_req),
		.queue_full(queue_full),
		.push(push),
		.push_req(push_req),
		.holding(holding)
	);

	genvar i;
	for (i = 0; i < `NUM_CORES; i++)
	begin : g_queue
		core_queue u_queue (
			.clk(clk),
			.reset(reset),
			.push(push[i]),
			.push_req(push_req),
			.full(queue_full[i]),
			.valid(queue_valid[i]),
			.head(queue_head[i]),
			.pop(pop[i])
		);
	end

	l2_store u_store (
		.clk(clk),
		.reset(reset),
		.req_valid(queue_valid),
		.req(queue_head),
		.pop(pop),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.active(active)
	);

endmodule

`default_nettype wire

/* gpgpu_cluster_tb.sv */
// Self-checking testbench for the cluster memory side
// Reads gpgpu_cluster_vectors.txt from the directory the simulator runs in
// Expected results come from a per-core request model and a model memory
// Loads must follow a store to the same address in response order
// First test uses random idle gaps, the later tests are back-to-back bursts
`timescale 1ns/10ps
`default_nettype none

`include "gpgpu_settings.svh"

module gpgpu_cluster_tb;
	import l2_pkg::*;
	import cluster_pkg::*;

	localparam int VEC_WORDS = 1024; // Raw words from the vector file
	localparam int EXP_DEPTH = 64; // Outstanding requests per core in the model

	logic clk;
	logic reset;
	logic host_valid;
	logic host_ready;
	l2_request_t host_req;
	logic rsp_valid;
	l2_response_t rsp;
	logic busy;

	logic [31:0] vec_mem [VEC_WORDS];
	l2_request_t exp_req [`NUM_CORES][EXP_DEPTH]; // Issued, not yet answered
	int exp_stamp [`NUM_CORES][EXP_DEPTH]; // Cycle each request was offered
	int exp_head [`NUM_CORES];
	int exp_cnt [`NUM_CORES];
	int last_rsp [`NUM_CORES]; // Cycle of the latest response per core
	l2_data_t model_mem [`MEM_WORDS];
	bit model_set [`MEM_WORDS]; // Address written at least once
	int num_tests;
	int total_vectors;
	int cycle;
	int sent_count;
	int rsp_count;
	int mismatches;
	int test_errors;
	int tests_ok;
	int tests_bad;
	logic loaded;
	logic [31:0] lfsr;

	gpgpu_cluster DUT (
		.clk(clk),
		.reset(reset),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.host_req(host_req),
		.rsp_valid(rsp_valid),
		.rsp(rsp),
		.busy(busy)
	);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk)
		cycle <= cycle + 1;

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic string test_name(input int t);
		case (t)
			0: return "mixed traffic with gaps";
			1: return "single-core burst";
			2: return "all-core burst";
			default: return "extra burst";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, actual, expected);
			mismatches++;
			test_errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		test_errors++;
	endtask

	// Two LFSR bits per gap, 0 to 3 idle cycles
	task automatic draw_gap(output int gap);
		logic [1:0] bits;
		lfsr = lfsr_step(lfsr);
		bits[0] = lfsr[0];
		lfsr = lfsr_step(lfsr);
		bits[1] = lfsr[0];
		gap = int'(bits);
	endtask

	task automatic push_expected(input l2_request_t r, input int stamp);
		int c;
		int slot;
		c = int'(r.core);
		if (exp_cnt[c] == EXP_DEPTH)
			report_failure($sformatf("model queue of core %0d overflowed", c));
		else
		begin
			slot = (exp_head[c] + exp_cnt[c]) % EXP_DEPTH;
			exp_req[c][slot] = r;
			exp_stamp[c][slot] = stamp;
			exp_cnt[c]++;
		end
	endtask

	// Called just after a rising edge, returns at the transfer edge
	task automatic send_request(input l2_request_t r);
		logic ready;
		ready = 1'b0;
		#1;
		host_valid = 1'b1;
		host_req = r;
		while (!ready)
		begin
			@(negedge clk);
			ready = host_ready; // Stable mid-cycle
			if (ready)
			begin
				push_expected(r, cycle);
				sent_count++;
			end
			@(posedge clk);
		end
	endtask

	task automatic handle_response();
		int c;
		l2_request_t e;
		c = int'(rsp.core);
		rsp_count++;
		if (exp_cnt[c] == 0)
		begin
			report_failure($sformatf("response for core %0d with no request outstanding", c));
			return;
		end
		e = exp_req[c][exp_head[c]]; // Oldest request of this core
		check_value("rsp.op", 64'(rsp.op), 64'(e.op));
		check_value("rsp.address", 64'(rsp.address), 64'(e.address));
		if (e.op == OP_LOAD)
		begin
			if (!model_set[e.address])
				report_failure($sformatf("load of address %0h that was never stored", e.address));
			else
				check_value("rsp.data", 64'(rsp.data), 64'(model_mem[e.address]));
		end
		else
		begin
			check_value("rsp.data", 64'(rsp.data), 64'(e.data)); // Store echo
			model_mem[e.address] = e.data;
			model_set[e.address] = 1'b1;
		end
		// A core waiting since before c's last grant must be served first
		for (int d = 0; d < `NUM_CORES; d++)
			if (d != c && last_rsp[c] >= 0 && exp_cnt[d] > 0 && last_rsp[d] < last_rsp[c]
				&& exp_stamp[d][exp_head[d]] <= last_rsp[c] - 4)
				report_failure($sformatf("core %0d served twice while core %0d waited", c, d));
		exp_head[c] = (exp_head[c] + 1) % EXP_DEPTH;
		exp_cnt[c]--;
		last_rsp[c] = cycle;
	endtask

	always @(negedge clk)
	begin
		if (reset === 1'b0 && rsp_valid === 1'b1)
			handle_response();
	end

	initial
	begin
		wait (loaded);
		repeat (20 * total_vectors + 100) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles, responses stopped arriving",
			20 * total_vectors + 100);
		$display("test failed");
		$finish;
	end

	initial
	begin
		int pos;
		int n;
		int gap;
		l2_request_t r;
		clk = 1'b0;
		reset = 1'b1;
		host_valid = 1'b0;
		host_req = '0;
		loaded = 1'b0;
		lfsr = 32'd71374;
		cycle = 0;
		sent_count = 0;
		rsp_count = 0;
		mismatches = 0;
		test_errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		total_vectors = 0;
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			exp_head[c] = 0;
			exp_cnt[c] = 0;
			last_rsp[c] = -1;
		end
		for (int a = 0; a < `MEM_WORDS; a++)
			model_set[a] = 1'b0;
		$readmemh("gpgpu_cluster_vectors.txt", vec_mem);
		num_tests = int'(vec_mem[0]);
		pos = 1;
		for (int t = 0; t < num_tests && t < 16; t++)
		begin
			total_vectors += int'(vec_mem[pos]);
			pos += 1 + 4 * int'(vec_mem[pos]);
		end
		if (num_tests < 1 || num_tests > 16 || pos > VEC_WORDS)
		begin
			$display("ERROR: vector file is missing, empty or malformed");
			tests_bad++;
			num_tests = 0;
		end
		else
			loaded = 1'b1;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		pos = 1;
		for (int t = 0; t < num_tests; t++)
		begin
			test_errors = 0;
			n = int'(vec_mem[pos]);
			pos++;
			for (int k = 0; k < n; k++)
			begin
				r.core = core_index_t'(vec_mem[pos]);
				r.op = l2_op_t'(vec_mem[pos + 1]);
				r.address = l2_addr_t'(vec_mem[pos + 2]);
				r.data = l2_data_t'(vec_mem[pos + 3]);
				pos += 4;
				send_request(r);
				if (t == 0)
				begin
					draw_gap(gap); // Bursts stay back to back
					if (gap != 0)
					begin
						#1 host_valid = 1'b0;
						repeat (gap) @(posedge clk);
					end
				end
			end
			#1 host_valid = 1'b0;
			while (rsp_count < sent_count) // Watchdog covers a hang
				@(posedge clk);
			@(negedge clk); // First cycle after the last response
			check_value("busy", 64'(busy), 64'd0);
			check_value("host_ready", 64'(host_ready), 64'd1);
			for (int c = 0; c < `NUM_CORES; c++)
				if (exp_cnt[c] != 0)
					report_failure($sformatf("core %0d has %0d requests never answered",
						c, exp_cnt[c]));
			$display("test %0d (%s): %0d requests, %0d errors", t + 1, test_name(t), n,
				test_errors);
			if (test_errors == 0)
				tests_ok++;
			else
				tests_bad++;
			@(posedge clk);
		end
		$display("summary: %0d tests ok, %0d tests with errors, %0d mismatches", tests_ok,
			tests_bad, mismatches);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* gpgpu_cluster_vectors.txt */
// Columns: core op address data, all hex; op 0 is a load, 1 a store
// First value is the test count, each test opens with its request count in hex
3
// Test 1: mixed traffic, loads only of addresses their own core stored
0c
0 1 00 11110000
1 1 10 22220001
2 1 20 33330002
3 1 30 44440003
0 1 01 5555aaaa
1 0 10 00000000
0 0 00 00000000
2 1 20 deadbeef
2 0 20 00000000
3 0 30 00000000
0 0 01 00000000
3 1 31 cafef00d
// Test 2: single-core burst on core 2
0a
2 1 02 a0000001
2 1 03 a0000002
2 0 02 00000000
2 0 00 00000000
2 0 10 00000000
2 1 02 a0000003
2 0 02 00000000
2 0 03 00000000
2 0 31 00000000
2 0 01 00000000
// Test 3: all cores loaded at once
10
0 1 3c 0c000000
1 1 3d 1d000000
2 1 3e 2e000000
3 1 3f 3f000000
0 0 3c 00000000
1 0 3d 00000000
2 0 3e 00000000
3 0 3f 00000000
0 0 30 00000000
1 0 20 00000000
2 0 10 00000000
3 0 00 00000000
0 1 3e 0c0000ee
1 0 02 00000000
2 0 31 00000000
3 0 01 00000000

/* gpgpu_cluster.f */
+incdir+.
cluster_pkg.sv
l2_pkg.sv
request_dispatch.sv
core_queue.sv
l2_store.sv
gpgpu_cluster.sv
gpgpu_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator, from the project root
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f gpgpu_cluster.f \
	--top-module gpgpu_cluster_tb -o gpgpu_cluster_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/gpgpu_cluster_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$log"; then
	exit 0
fi
exit 1
